//--- lm_params.svh
`ifndef LM_PARAMS_SVH
`define LM_PARAMS_SVH

// Build-wide constants of the local memory subsystem

// Number of independent banks, each with its own Avalon-MM agent port
`define LM_NUM_BANKS 2

// Word address width, so each bank holds 2**8 words
`define LM_ADDR_WIDTH 8

// Width of one data word on the bus and in the array
`define LM_DATA_WIDTH 64

// Bits covered by a single byteenable bit
`define LM_SYMBOL_WIDTH 8

// Burstcount width, bursts of 1 to 8 beats are used
`define LM_BURST_CNT_WIDTH 4

// Cycles from an array read request to valid read data
`define LM_READ_LATENCY 2

`endif

//--- avmm_pkg.sv
`include "lm_params.svh"

// Types that describe traffic on the Avalon-MM side of a bank
package avmm_pkg;

   // Symbols per data word, one byteenable bit each
   localparam int AVMM_BYTES = `LM_DATA_WIDTH / `LM_SYMBOL_WIDTH;

   typedef logic [`LM_ADDR_WIDTH-1:0]      avmm_addr_t;
   typedef logic [`LM_BURST_CNT_WIDTH-1:0] avmm_bcnt_t;
   typedef logic [`LM_DATA_WIDTH-1:0]      avmm_data_t;
   typedef logic [AVMM_BYTES-1:0]          avmm_be_t;

   // One accepted command beat as seen by the host
   typedef struct packed {
      logic       read;
      logic       write;
      avmm_addr_t address;
      avmm_bcnt_t burstcount;
      avmm_data_t writedata;
      avmm_be_t   byteenable;
   } avmm_cmd_t;

   // One read return travelling back to the host
   typedef struct packed {
      logic       valid;
      avmm_data_t data;
   } avmm_rsp_t;

endpackage

//--- mem_pkg.sv
`include "lm_params.svh"

// Types that describe the storage side of a bank
package mem_pkg;

   // Symbols per stored word, one write enable each
   localparam int MEM_BYTES = `LM_DATA_WIDTH / `LM_SYMBOL_WIDTH;

   // A single array access, at most one per cycle
   typedef struct packed {
      logic                          read;
      logic                          write;
      logic [`LM_ADDR_WIDTH-1:0]     addr;
      logic [`LM_DATA_WIDTH-1:0]     wdata;
      logic [MEM_BYTES-1:0]          be;
   } mem_req_t;

   // One stage of the read latency chain
   // The last stage doubles as the array read response
   typedef struct packed {
      logic                      valid;
      logic [`LM_DATA_WIDTH-1:0] data;
   } rd_pipe_t;

endpackage

//--- avmm_if.sv
`timescale 1ns/1ps

// Avalon-MM link between a bank's bridge and its burst controller
// All signals are sampled on the shared clk
interface avmm_if;
   import avmm_pkg::*;

   // Command channel, driven by the host
   avmm_addr_t address;
   logic       read;
   logic       write;
   avmm_bcnt_t burstcount;
   avmm_data_t writedata;
   avmm_be_t   byteenable;

   // Flow control and read return, driven by the agent
   logic       waitrequest;
   avmm_data_t readdata;
   logic       readdatavalid;

   // The bridge issues commands on its memory side
   modport host
   (
      output address, read, write, burstcount, writedata, byteenable,
      input  waitrequest, readdata, readdatavalid
   );

   // The burst controller answers them
   modport agent
   (
      input  address, read, write, burstcount, writedata, byteenable,
      output waitrequest, readdata, readdatavalid
   );

endinterface

//--- avmm_bridge.sv
`timescale 1ns/1ps

// Registered pipeline bridge in front of one bank
// Every path between the host port and the memory side goes through a flop
module avmm_bridge
(
   input  logic                 clk,
   input  logic                 rst_n,

   // Host side, plain Avalon-MM agent signals
   input  avmm_pkg::avmm_addr_t address,
   input  logic                 read,
   input  logic                 write,
   input  avmm_pkg::avmm_bcnt_t burstcount,
   input  avmm_pkg::avmm_data_t writedata,
   input  avmm_pkg::avmm_be_t   byteenable,
   output logic                 waitrequest,
   output avmm_pkg::avmm_data_t readdata,
   output logic                 readdatavalid,

   // Memory side towards the burst controller
   avmm_if.host                 mem
);
   import avmm_pkg::*;

   avmm_cmd_t host_beat;
   avmm_cmd_t out_q;
   avmm_cmd_t skid_q;
   logic      out_valid;
   logic      skid_valid;
   logic      wait_q;
   logic      host_acc;
   logic      out_free;
   logic      out_valid_nxt;
   logic      skid_valid_nxt;
   avmm_rsp_t rsp_q;

   // Gather the host signals into one beat
   always_comb
   begin
      host_beat.read       = read;
      host_beat.write      = write;
      host_beat.address    = address;
      host_beat.burstcount = burstcount;
      host_beat.writedata  = writedata;
      host_beat.byteenable = byteenable;
   end

   // A host beat transfers when a command is present and we are not stalling
   assign host_acc = (read | write) & ~wait_q;

   // The output register can load when it is empty or the agent takes it now
   assign out_free = ~out_valid | ~mem.waitrequest;

   // Next occupancy of the output and skid registers
   // The skid register is empty whenever wait_q is low, so the host and
   // the skid never compete for the output register
   always_comb
   begin
      out_valid_nxt  = out_valid;
      skid_valid_nxt = skid_valid;
      if (out_free)
      begin
         out_valid_nxt  = skid_valid | host_acc;
         skid_valid_nxt = 1'b0;
      end
      else if (host_acc)
      begin
         // Output is stalled, park the new beat in the skid register
         skid_valid_nxt = 1'b1;
      end
   end

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         out_valid  <= 1'b0;
         skid_valid <= 1'b0;
         // Hold the host off until reset is released
         wait_q     <= 1'b1;
      end
      else
      begin
         out_valid  <= out_valid_nxt;
         skid_valid <= skid_valid_nxt;
         // Host waitrequest follows skid occupancy one cycle later
         wait_q     <= skid_valid_nxt;
      end
   end

   // Command payload, qualified by the valid flags above
   always_ff @(posedge clk)
   begin
      if (out_free)
      begin
         out_q <= skid_valid ? skid_q : host_beat;
      end
      if (host_acc && !out_free)
      begin
         skid_q <= host_beat;
      end
   end

   assign waitrequest = wait_q;

   // Drive the memory side straight from the output register
   assign mem.address    = out_q.address;
   assign mem.read       = out_valid & out_q.read;
   assign mem.write      = out_valid & out_q.write;
   assign mem.burstcount = out_q.burstcount;
   assign mem.writedata  = out_q.writedata;
   assign mem.byteenable = out_q.byteenable;

   // Read returns are registered once on the way back
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         rsp_q <= '0;
      end
      else
      begin
         rsp_q.valid <= mem.readdatavalid;
         rsp_q.data  <= mem.readdata;
      end
   end

   assign readdatavalid = rsp_q.valid;
   assign readdata      = rsp_q.data;

endmodule

//--- mem_burst_ctrl.sv
`timescale 1ns/1ps
`include "lm_params.svh"

// Burst sequencer of one bank
// Turns Avalon-MM bursts into one array access per cycle
module mem_burst_ctrl
(
   input  logic              clk,
   input  logic              rst_n,
   avmm_if.agent             bus,
   output mem_pkg::mem_req_t req,
   input  mem_pkg::rd_pipe_t rsp
);
   import avmm_pkg::*;
   import mem_pkg::*;

   localparam logic [`LM_ADDR_WIDTH-1:0]      ADDR_STEP = 1;
   localparam logic [`LM_BURST_CNT_WIDTH-1:0] ONE_BEAT  = 1;

   avmm_cmd_t                     beat;
   logic                          accept;
   logic                          rd_busy;
   logic                          wr_busy;
   logic [`LM_ADDR_WIDTH-1:0]     rd_addr;
   logic [`LM_BURST_CNT_WIDTH-1:0] rd_left;
   logic [`LM_ADDR_WIDTH-1:0]     wr_addr;
   logic [`LM_BURST_CNT_WIDTH-1:0] wr_left;

   // View the incoming bus signals as a single command beat
   always_comb
   begin
      beat.read       = bus.read;
      beat.write      = bus.write;
      beat.address    = bus.address;
      beat.burstcount = bus.burstcount;
      beat.writedata  = bus.writedata;
      beat.byteenable = bus.byteenable;
   end

   // Read words still to be issued after the first one
   assign rd_busy = (rd_left != '0);
   // Write beats still expected after the first one
   assign wr_busy = (wr_left != '0);

   // Only a read burst stalls the bus, write beats always flow
   assign bus.waitrequest = rd_busy;
   assign accept          = (bus.read | bus.write) & ~rd_busy;

   // One array request per cycle
   always_comb
   begin
      req = '0;
      if (rd_busy)
      begin
         // Remaining words of the current read burst
         req.read = 1'b1;
         req.addr = rd_addr;
      end
      else if (accept && beat.read)
      begin
         // First word goes out in the same cycle the command is taken
         req.read = 1'b1;
         req.addr = beat.address;
      end
      else if (accept && beat.write)
      begin
         req.write = 1'b1;
         // Later beats of a burst ignore the address on the bus
         req.addr  = wr_busy ? wr_addr : beat.address;
         req.wdata = beat.writedata;
         req.be    = beat.byteenable;
      end
   end

   // Burst state: next address and beats remaining for each direction
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         rd_addr <= '0;
         rd_left <= '0;
         wr_addr <= '0;
         wr_left <= '0;
      end
      else
      begin
         if (rd_busy)
         begin
            rd_addr <= rd_addr + ADDR_STEP;
            rd_left <= rd_left - ONE_BEAT;
         end
         else if (accept && beat.read && beat.burstcount > ONE_BEAT)
         begin
            rd_addr <= beat.address + ADDR_STEP;
            rd_left <= beat.burstcount - ONE_BEAT;
         end

         if (accept && beat.write)
         begin
            if (wr_busy)
            begin
               wr_addr <= wr_addr + ADDR_STEP;
               wr_left <= wr_left - ONE_BEAT;
            end
            else if (beat.burstcount > ONE_BEAT)
            begin
               // Address and length come from the first beat only
               wr_addr <= beat.address + ADDR_STEP;
               wr_left <= beat.burstcount - ONE_BEAT;
            end
         end
      end
   end

   // Array returns go straight back, readdatavalid cannot be stalled
   assign bus.readdatavalid = rsp.valid;
   assign bus.readdata      = rsp.data;

endmodule

//--- mem_array.sv
`timescale 1ns/1ps
`include "lm_params.svh"

// Byte-enabled word storage of one bank
// Reads come out a fixed number of cycles after the request
module mem_array
(
   input  logic              clk,
   input  logic              rst_n,
   input  mem_pkg::mem_req_t req,
   output mem_pkg::rd_pipe_t rsp
);
   import mem_pkg::*;

   localparam int NBYTES = `LM_DATA_WIDTH / `LM_SYMBOL_WIDTH;
   localparam int SW     = `LM_SYMBOL_WIDTH;
   localparam int DEPTH  = 1 << `LM_ADDR_WIDTH;
   localparam int LAT    = `LM_READ_LATENCY;

   logic [`LM_DATA_WIDTH-1:0] store [DEPTH];
   rd_pipe_t                  pipe [LAT];

   // Only the enabled symbols of the word are updated
   always_ff @(posedge clk)
   begin
      if (req.write)
      begin
         for (int i = 0; i < NBYTES; i++)
         begin
            if (req.be[i])
            begin
               store[req.addr][i*SW +: SW] <= req.wdata[i*SW +: SW];
            end
         end
      end
   end

   // Read latency chain, one new read may enter every cycle
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         for (int i = 0; i < LAT; i++)
         begin
            pipe[i] <= '0;
         end
      end
      else
      begin
         pipe[0].valid <= req.read;
         pipe[0].data  <= store[req.addr];
         // Older reads move one stage on
         for (int i = 1; i < LAT; i++)
         begin
            pipe[i] <= pipe[i-1];
         end
      end
   end

   assign rsp = pipe[LAT-1];

endmodule

//--- local_mem_top.sv
`timescale 1ns/1ps
`include "lm_params.svh"

// Local memory subsystem with one independent bank per Avalon-MM port
// Each bank is bridge, burst controller and storage array in series
module local_mem_top
(
   input  logic                 clk,
   input  logic                 rst_n,

   // Per-bank command inputs
   input  avmm_pkg::avmm_addr_t address       [`LM_NUM_BANKS],
   input  logic                 read          [`LM_NUM_BANKS],
   input  logic                 write         [`LM_NUM_BANKS],
   input  avmm_pkg::avmm_bcnt_t burstcount    [`LM_NUM_BANKS],
   input  avmm_pkg::avmm_data_t writedata     [`LM_NUM_BANKS],
   input  avmm_pkg::avmm_be_t   byteenable    [`LM_NUM_BANKS],

   // Per-bank flow control and read return
   output logic                 waitrequest   [`LM_NUM_BANKS],
   output avmm_pkg::avmm_data_t readdata      [`LM_NUM_BANKS],
   output logic                 readdatavalid [`LM_NUM_BANKS]
);
   import mem_pkg::*;

   for (genvar b = 0; b < `LM_NUM_BANKS; b++)
   begin : g_bank
      // Link between the bridge and the burst controller
      avmm_if bus ();

      // Array side of the bank
      mem_req_t req;
      rd_pipe_t rsp;

      avmm_bridge u_bridge
      (
         .clk           (clk),
         .rst_n         (rst_n),
         .address       (address[b]),
         .read          (read[b]),
         .write         (write[b]),
         .burstcount    (burstcount[b]),
         .writedata     (writedata[b]),
         .byteenable    (byteenable[b]),
         .waitrequest   (waitrequest[b]),
         .readdata      (readdata[b]),
         .readdatavalid (readdatavalid[b]),
         .mem           (bus)
      );

      mem_burst_ctrl u_ctrl
      (
         .clk   (clk),
         .rst_n (rst_n),
         .bus   (bus),
         .req   (req),
         .rsp   (rsp)
      );

      mem_array u_array
      (
         .clk   (clk),
         .rst_n (rst_n),
         .req   (req),
         .rsp   (rsp)
      );
   end

endmodule

//--- tb_local_mem.sv
`timescale 1ns/1ps
`include "lm_params.svh"

// Testbench for the two-bank local memory, acting as Avalon-MM host on every bank
module tb_local_mem;
   import avmm_pkg::*;

   localparam int NB          = `LM_NUM_BANKS;
   localparam int NBYTES      = `LM_DATA_WIDTH / `LM_SYMBOL_WIDTH;
   localparam int SW          = `LM_SYMBOL_WIDTH;
   // Bridge command stage, bridge response stage and the array latency
   localparam int RD_LAT_TOP  = 2 + `LM_READ_LATENCY;
   localparam int QD          = 128;
   localparam int NUM_ENTRIES = 22;
   localparam int CYCLE_LIMIT = NUM_ENTRIES * 20 + 100;

   localparam logic [1:0] OP_WR = 2'd1;
   localparam logic [1:0] OP_RD = 2'd2;

   // One table row, dsel 0 takes write data from the LCG
   // Any other dsel writes that byte value plus the beat index into every byte
   typedef struct packed {
      logic [1:0] op;
      logic [7:0] bank;
      avmm_addr_t addr;
      avmm_bcnt_t bcnt;
      avmm_be_t   be;
      logic [7:0] dsel;
   } entry_t;

   localparam entry_t STIM [NUM_ENTRIES] = '{
      '{OP_WR, 8'd0, 8'h10, 4'd1, 8'hFF, 8'h00},
      '{OP_RD, 8'd0, 8'h10, 4'd1, 8'hFF, 8'h00},
      '{OP_WR, 8'd0, 8'h20, 4'd8, 8'hFF, 8'h00},
      '{OP_RD, 8'd0, 8'h20, 4'd8, 8'hFF, 8'h00},
      '{OP_WR, 8'd1, 8'h40, 4'd1, 8'hFF, 8'h00},
      '{OP_WR, 8'd1, 8'h40, 4'd1, 8'h5A, 8'h33},
      '{OP_RD, 8'd1, 8'h40, 4'd1, 8'hFF, 8'h00},
      '{OP_WR, 8'd0, 8'h20, 4'd4, 8'h0F, 8'h11},
      '{OP_RD, 8'd0, 8'h20, 4'd8, 8'hFF, 8'h00},
      '{OP_WR, 8'd0, 8'h80, 4'd1, 8'hFF, 8'h00},
      '{OP_WR, 8'd1, 8'h80, 4'd1, 8'hFF, 8'h00},
      '{OP_RD, 8'd0, 8'h80, 4'd1, 8'hFF, 8'h00},
      '{OP_RD, 8'd1, 8'h80, 4'd1, 8'hFF, 8'h00},
      '{OP_WR, 8'd1, 8'h00, 4'd8, 8'hFF, 8'h00},
      '{OP_RD, 8'd1, 8'h00, 4'd8, 8'hFF, 8'h00},
      '{OP_RD, 8'd1, 8'h04, 4'd4, 8'hFF, 8'h00},
      '{OP_RD, 8'd1, 8'h02, 4'd2, 8'hFF, 8'h00},
      '{OP_RD, 8'd1, 8'h00, 4'd1, 8'hFF, 8'h00},
      '{OP_RD, 8'd1, 8'h06, 4'd2, 8'hFF, 8'h00},
      '{OP_RD, 8'd0, 8'h20, 4'd8, 8'hFF, 8'h00},
      '{OP_RD, 8'd0, 8'h10, 4'd1, 8'hFF, 8'h00},
      '{OP_RD, 8'd0, 8'h80, 4'd1, 8'hFF, 8'h00}
   };

   logic       clk;
   logic       rst_n;
   avmm_addr_t host_addr  [NB];
   logic       host_read  [NB];
   logic       host_write [NB];
   avmm_bcnt_t host_bcnt  [NB];
   avmm_data_t host_wdata [NB];
   avmm_be_t   host_be    [NB];
   logic       wait_req   [NB];
   avmm_data_t rd_data    [NB];
   logic       rd_valid   [NB];

   // Reference contents of each bank and the words still owed per bank
   avmm_data_t  ref_mem  [NB][1 << `LM_ADDR_WIDTH];
   avmm_data_t  exp_data [NB][QD];
   avmm_addr_t  exp_addr [NB][QD];
   int          exp_cyc  [NB][QD];
   int          wr_ptr   [NB];
   int          rd_ptr   [NB];
   int          last_cyc [NB];
   int          cyc = 0;
   int          seq_errs;
   int          mon_data_errs;
   int          mon_other_errs;
   logic [31:0] lcg_state;

   local_mem_top dut
   (
      .clk           (clk),
      .rst_n         (rst_n),
      .address       (host_addr),
      .read          (host_read),
      .write         (host_write),
      .burstcount    (host_bcnt),
      .writedata     (host_wdata),
      .byteenable    (host_be),
      .waitrequest   (wait_req),
      .readdata      (rd_data),
      .readdatavalid (rd_valid)
   );

   initial
   begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   // Cycle count doubles as the time base for latency checks
   always @(posedge clk)
   begin
      cyc <= cyc + 1;
      if (cyc >= CYCLE_LIMIT)
      begin
         $display("Timeout after %0d cycles, read words were still missing or a beat hung", cyc);
         $display("Errors: %0d data mismatches, %0d other failures",
                  mon_data_errs, mon_other_errs + seq_errs);
         $display("Test FAILED");
         $finish;
      end
   end

   function automatic logic [31:0] lcg_next();
      lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
      return lcg_state;
   endfunction

   function automatic avmm_data_t make_data(input logic [7:0] dsel, input int beat);
      logic [31:0] hi;
      logic [31:0] lo;
      logic [7:0]  pat;
      if (dsel == 8'h00)
      begin
         hi = lcg_next();
         lo = lcg_next();
         return {hi, lo};
      end
      pat = dsel + beat[7:0];
      return {NBYTES{pat}};
   endfunction

   // Only symbols with their byteenable bit set take the new value
   function automatic avmm_data_t merge_bytes(input avmm_data_t old_w, input avmm_data_t new_w,
                                              input avmm_be_t be);
      avmm_data_t res;
      res = old_w;
      for (int i = 0; i < NBYTES; i++)
      begin
         if (be[i])
         begin
            res[i*SW +: SW] = new_w[i*SW +: SW];
         end
      end
      return res;
   endfunction

   function automatic logic reads_pending();
      logic busy;
      busy = 1'b0;
      for (int b = 0; b < NB; b++)
      begin
         busy = busy | (rd_ptr[b] != wr_ptr[b]);
      end
      return busy;
   endfunction

   // Present one beat and hold it until the bank takes it
   // acc_cyc is the cycle in which the beat transferred
   task automatic issue_beat(input int b, input logic rd, input logic wr, input avmm_addr_t a,
                             input avmm_bcnt_t bc, input avmm_data_t wd, input avmm_be_t be,
                             output int acc_cyc);
      host_read[b]  = rd;
      host_write[b] = wr;
      host_addr[b]  = a;
      host_bcnt[b]  = bc;
      host_wdata[b] = wd;
      host_be[b]    = be;
      while (wait_req[b] !== 1'b0)
      begin
         @(posedge clk);
         #1;
      end
      acc_cyc = cyc;
      @(posedge clk);
      #1;
      host_read[b]  = 1'b0;
      host_write[b] = 1'b0;
   endtask

   task automatic wait_reads_done();
      while (reads_pending())
      begin
         @(posedge clk);
         #1;
      end
   endtask

   task automatic run_write(input entry_t e);
      int         b;
      int         acc;
      avmm_addr_t a;
      avmm_data_t wd;
      b = int'(e.bank);
      // Outstanding reads see the old contents, so let them finish first
      wait_reads_done();
      for (int k = 0; k < int'(e.bcnt); k++)
      begin
         wd = make_data(e.dsel, k);
         issue_beat(b, 1'b0, 1'b1, e.addr, e.bcnt, wd, e.be, acc);
         a = e.addr + avmm_addr_t'(k);
         ref_mem[b][a] = merge_bytes(ref_mem[b][a], wd, e.be);
      end
   endtask

   task automatic run_read(input entry_t e);
      int         b;
      int         acc;
      int         want;
      int         slot;
      avmm_addr_t a;
      b = int'(e.bank);
      issue_beat(b, 1'b1, 1'b0, e.addr, e.bcnt, '0, '1, acc);
      for (int k = 0; k < int'(e.bcnt); k++)
      begin
         a    = e.addr + avmm_addr_t'(k);
         want = acc + RD_LAT_TOP + k;
         // A read queued behind an earlier burst follows its last word directly
         if (want <= last_cyc[b])
         begin
            want = last_cyc[b] + 1;
         end
         slot = wr_ptr[b] % QD;
         exp_data[b][slot] = ref_mem[b][a];
         exp_addr[b][slot] = a;
         exp_cyc[b][slot]  = want;
         last_cyc[b]       = want;
         wr_ptr[b]++;
      end
   endtask

   // Read monitor, sampled mid-cycle where the registered outputs are stable
   always @(negedge clk)
   begin
      int slot;
      if (!rst_n)
      begin
         mon_data_errs  = 0;
         mon_other_errs = 0;
         for (int b = 0; b < NB; b++)
         begin
            rd_ptr[b] = 0;
         end
      end
      else
      begin
         for (int b = 0; b < NB; b++)
         begin
            if (rd_valid[b] === 1'b1)
            begin
               assert (rd_ptr[b] != wr_ptr[b])
               else
               begin
                  mon_other_errs++;
                  $display("Bank %0d returned read data at %0t with no read outstanding",
                           b, $time);
               end
               if (rd_ptr[b] != wr_ptr[b])
               begin
                  slot = rd_ptr[b] % QD;
                  assert (rd_data[b] === exp_data[b][slot])
                  else
                  begin
                     mon_data_errs++;
                     $display("ERR %0t bank %0d addr 0x%02h expected 0x%016h actual 0x%016h",
                              $time, b, exp_addr[b][slot], exp_data[b][slot], rd_data[b]);
                  end
                  assert (cyc == exp_cyc[b][slot])
                  else
                  begin
                     mon_other_errs++;
                     $display("Bank %0d word at 0x%02h came in cycle %0d instead of cycle %0d",
                              b, exp_addr[b][slot], cyc, exp_cyc[b][slot]);
                  end
                  rd_ptr[b]++;
               end
            end
         end
      end
   end

   initial
   begin
      rst_n     = 1'b0;
      seq_errs  = 0;
      lcg_state = 32'd80;
      for (int b = 0; b < NB; b++)
      begin
         host_addr[b]  = '0;
         host_read[b]  = 1'b0;
         host_write[b] = 1'b0;
         host_bcnt[b]  = '0;
         host_wdata[b] = '0;
         host_be[b]    = '0;
         wr_ptr[b]     = 0;
         last_cyc[b]   = 0;
      end
      repeat (2) @(posedge clk);
      for (int b = 0; b < NB; b++)
      begin
         assert (wait_req[b] === 1'b1)
         else
         begin
            seq_errs++;
            $display("Bank %0d waitrequest is not high during reset", b);
         end
      end
      #1 rst_n = 1'b1;
      // Both banks must be ready one cycle after reset is released
      @(posedge clk);
      #1;
      for (int b = 0; b < NB; b++)
      begin
         assert (wait_req[b] === 1'b0 && rd_valid[b] === 1'b0)
         else
         begin
            seq_errs++;
            $display("Bank %0d is not idle and ready in the first cycle after reset", b);
         end
      end
      for (int i = 0; i < NUM_ENTRIES; i++)
      begin
         if (STIM[i].op == OP_WR)
         begin
            run_write(STIM[i]);
         end
         else
         begin
            run_read(STIM[i]);
         end
      end
      wait_reads_done();
      // Idle a while so that a duplicated return would still be seen
      repeat (10)
      begin
         @(posedge clk);
         #1;
      end
      $display("Errors: %0d data mismatches, %0d other failures",
               mon_data_errs, mon_other_errs + seq_errs);
      if (mon_data_errs + mon_other_errs + seq_errs == 0)
      begin
         $display("Test OK");
      end
      else
      begin
         $display("Test FAILED");
      end
      $finish;
   end

endmodule

//--- all.f
+incdir+.
avmm_pkg.sv
mem_pkg.sv
avmm_if.sv
avmm_bridge.sv
mem_burst_ctrl.sv
mem_array.sv
local_mem_top.sv
tb_local_mem.sv

//--- run.sh
#!/bin/sh
# Build the testbench with Verilator, run it, then judge the run from its log

verilator --binary --timing --assert --top-module tb_local_mem -f all.f > build.log 2>&1 \
   && ./obj_dir/Vtb_local_mem > sim.log 2>&1 \
   || { cat build.log sim.log 2>/dev/null; echo "Build or simulation did not complete"; exit 1; }

cat sim.log

grep -q "Test FAILED" sim.log \
   && { echo "Simulation reported a failure"; exit 1; } \
   || exit 0
